/* project.f */
common/board_pkg.sv
common/lcd_cmd_if.sv
logic/timebase.sv
logic/delay_timer.sv
display/seven_segment_mux.sv
display/tm1638_driver.sv
hx8352/hx8352_bus_writer.sv
hx8352/hx8352_sequencer.sv
logic/system.sv
testbench/tb_system.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_system
CLK_PER_US ?= 2
US_PER_SEC ?= 400
VFLAGS     ?= --binary --timing --assert -j 0
BUILD_DIR  ?= build/$(TOP)_$(CLK_PER_US)_$(US_PER_SEC)
FILE_LIST  := project.f
SOURCES    := $(shell grep -v '^+' $(FILE_LIST))
BIN        := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILE_LIST) Makefile
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) \
		-GCLK_PER_US=$(CLK_PER_US) -GUS_PER_SEC=$(US_PER_SEC) -f $(FILE_LIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -q '^TESTBENCH PASSED$$'

clean:
	rm -rf build

/* testbench/tb_system.sv */
`timescale 1ns/100ps

module tb_system #(
	parameter int CLK_PER_US = 2,
	parameter int US_PER_SEC = 400
);
	localparam int RESET_US    = 5;
	localparam int WR_LOW      = 2;
	localparam int CLK_NS      = 4;
	localparam int SEC_CYCLES  = CLK_PER_US * US_PER_SEC;
	localparam int WATCHDOG_NS = 7 * SEC_CYCLES * CLK_NS; // Six seconds of tests and one spare.

	localparam logic [15:0] GRAM_WORD = 16'h0022;
	localparam logic [7:0]  ADDR_CMD  = 8'hC0;
	localparam logic [7:0]  CTRL_CMD  = 8'h8C;

	// Init table as it appears on the bus, index then value.
	localparam logic [191:0] INIT_WORDS = {
		16'h001A, 16'h0002, 16'h001B, 16'h0088, 16'h0023, 16'h0000,
		16'h0018, 16'h0036, 16'h0019, 16'h0001, 16'h0028, 16'h0038
	};

	// Digit F in the top slot, digit 0 at the bottom.
	localparam logic [111:0] SEG_TABLE = {
		7'h71, 7'h79, 7'h5E, 7'h39, 7'h7C, 7'h77, 7'h6F, 7'h7F,
		7'h07, 7'h7D, 7'h6D, 7'h66, 7'h4F, 7'h5B, 7'h06, 7'h3F
	};

	logic        clk_50M;
	logic        rst_n;
	logic        led;
	logic [7:0]  display_7seg_bus;
	logic [2:0]  display_7seg_anodes;
	logic        tm1638_clk;
	logic        tm1638_data;
	logic        tm1638_strobe;
	logic [15:0] hx8352_data;
	logic        hx8352_rs;
	logic        hx8352_wr;
	logic        hx8352_rd;
	logic        hx8352_cs;
	logic        hx8352_rst;

	logic [15:0] lcd_words [$];
	logic        lcd_rs [$];
	int          cs_errors   = 0;
	logic [7:0]  tm_bytes [$];
	int          tm_groups [$];
	int          tm_group_len = 0;
	int          tm_bits      = 0;
	logic [7:0]  tm_shift     = 8'h00;
	logic        strobe_seen  = 1'b1;
	logic        clk_seen     = 1'b1;
	logic [15:0] led_count    = 16'd0;
	real         release_ns   = 0.0;
	real         rst_rise_ns  = 0.0;
	string       test_name    = "setup";

	system #(
		.CLK_PER_US(CLK_PER_US),
		.US_PER_SEC(US_PER_SEC),
		.RESET_US  (RESET_US),
		.WR_LOW    (WR_LOW)
	) i_system (
		.clk_50M            (clk_50M),
		.rst_n              (rst_n),
		.led                (led),
		.display_7seg_bus   (display_7seg_bus),
		.display_7seg_anodes(display_7seg_anodes),
		.tm1638_clk         (tm1638_clk),
		.tm1638_data        (tm1638_data),
		.tm1638_strobe      (tm1638_strobe),
		.hx8352_data        (hx8352_data),
		.hx8352_rs          (hx8352_rs),
		.hx8352_wr          (hx8352_wr),
		.hx8352_rd          (hx8352_rd),
		.hx8352_cs          (hx8352_cs),
		.hx8352_rst         (hx8352_rst)
	);

	initial clk_50M = 1'b0;
	always #(CLK_NS / 2) clk_50M = ~clk_50M;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus monitors
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always @(hx8352_wr) begin
		if (rst_n === 1'b1) begin
			if (hx8352_cs !== 1'b0)
				cs_errors++; // Strobe edge outside cs.
			if (hx8352_wr === 1'b1) begin
				lcd_words.push_back(hx8352_data);
				lcd_rs.push_back(hx8352_rs);
			end
		end
	end

	always @(posedge hx8352_rst) begin
		if (rst_n === 1'b1)
			rst_rise_ns = $realtime;
	end

	always @(tm1638_clk or tm1638_strobe) begin
		if (rst_n === 1'b1) begin
			if (tm1638_strobe !== strobe_seen) begin
				if (tm1638_strobe === 1'b0) begin
					tm_group_len = 0;
					tm_bits      = 0;
				end else begin
					tm_groups.push_back(tm_group_len);
				end
			end else if (tm1638_clk === 1'b1 && clk_seen === 1'b0) begin
				tm_shift = {tm1638_data, tm_shift[7:1]}; // LSB arrives first.
				tm_bits++;
				if (tm_bits == 8) begin
					tm_bytes.push_back(tm_shift);
					tm_group_len++;
					tm_bits = 0;
				end
			end
		end
		strobe_seen = tm1638_strobe;
		clk_seen    = tm1638_clk;
	end

	always @(led) begin
		if (rst_n === 1'b1)
			led_count = led_count + 16'd1; // One edge per second.
	end

	initial begin
		#(WATCHDOG_NS);
		report_failure("watchdog expired before all tests finished");
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model and reporting
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [6:0] seg_ref(input logic [3:0] nib);
		return 7'(SEG_TABLE >> (7 * nib));
	endfunction

	function automatic logic [15:0] rgb_pixel(input logic [15:0] count);
		return {count[4:0], 6'b000000, ~count[4:0]};
	endfunction

	task automatic abort_run();
		$display("TESTBENCH FAILED");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic value_mismatch(input string what, input logic [31:0] exp,
			input logic [31:0] act);
		$display("ERROR %s: %s expected 0x%0h, actual 0x%0h", test_name, what, exp, act);
		abort_run();
	endtask

	task automatic report_failure(input string text);
		$display("%s: %s", test_name, text);
		abort_run();
	endtask

	task automatic compare_value(input string what, input logic [31:0] exp,
			input logic [31:0] act);
		assert (act === exp) else value_mismatch(what, exp, act);
	endtask

	task automatic idle_outputs(input string where);
		compare_value({where, " hx8352_cs"}, 32'd1, 32'(hx8352_cs));
		compare_value({where, " hx8352_wr"}, 32'd1, 32'(hx8352_wr));
		compare_value({where, " hx8352_rd"}, 32'd1, 32'(hx8352_rd));
		compare_value({where, " hx8352_rst"}, 32'd0, 32'(hx8352_rst));
		compare_value({where, " tm1638_strobe"}, 32'd1, 32'(tm1638_strobe));
		compare_value({where, " tm1638_clk"}, 32'd1, 32'(tm1638_clk));
		compare_value({where, " anodes"}, 32'h7, 32'(display_7seg_anodes));
		compare_value({where, " segments"}, 32'hFF, 32'(display_7seg_bus));
	endtask

	task automatic wait_led_toggle();
		logic [15:0] start_count;
		int          cycles;
		start_count = led_count;
		cycles      = 0;
		while (led_count == start_count) begin
			@(negedge clk_50M);
			cycles++;
			assert (cycles <= 2 * SEC_CYCLES) else report_failure("led did not toggle in two seconds");
		end
	endtask

	task automatic lcd_words_arrive(input int needed);
		int cycles;
		cycles = 0;
		while (lcd_words.size() < needed) begin
			@(negedge clk_50M);
			cycles++;
			assert (cycles <= SEC_CYCLES) else report_failure("LCD bus writes stopped arriving");
		end
	endtask

	task automatic tm_groups_arrive(input int needed);
		int cycles;
		cycles = 0;
		while (tm_groups.size() < needed) begin
			@(negedge clk_50M);
			cycles++;
			assert (cycles <= SEC_CYCLES) else report_failure("TM1638 frame did not complete");
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic reset_state();
		test_name = "reset_state";
		repeat (5) begin
			@(negedge clk_50M);
			idle_outputs("in reset");
		end
		rst_n      = 1'b1;
		release_ns = $realtime;
		@(negedge clk_50M);
		idle_outputs("after reset");
	endtask

	task automatic lcd_init();
		int cycles;
		int i;
		test_name = "lcd_init";
		cycles    = 0;
		while (hx8352_rst !== 1'b1) begin
			@(negedge clk_50M);
			cycles++;
			assert (cycles <= SEC_CYCLES) else report_failure("LCD reset was never released");
		end
		assert (rst_rise_ns - release_ns >= real'(RESET_US * CLK_PER_US * CLK_NS))
			else report_failure("LCD reset pulse was shorter than RESET_US");
		lcd_words_arrive(12);
		for (i = 0; i < 12; i++) begin
			compare_value($sformatf("word %0d", i), 32'(16'(INIT_WORDS >> (16 * (11 - i)))),
				32'(lcd_words[i]));
			compare_value($sformatf("rs of word %0d", i), 32'(i % 2), 32'(lcd_rs[i]));
		end
		assert (cs_errors == 0) else report_failure("write strobe moved while cs was high");
	endtask

	task automatic lcd_pixel();
		logic [15:0] count;
		int          base;
		int          n;
		test_name = "lcd_pixel";
		for (n = 0; n < 3; n++) begin
			wait_led_toggle();
			count = led_count;
			base  = lcd_words.size();
			lcd_words_arrive(base + 2);
			compare_value("GRAM index", 32'(GRAM_WORD), 32'(lcd_words[base]));
			compare_value("GRAM index rs", 32'd0, 32'(lcd_rs[base]));
			compare_value("pixel", 32'(rgb_pixel(count)), 32'(lcd_words[base + 1]));
			compare_value("pixel rs", 32'd1, 32'(lcd_rs[base + 1]));
		end
		assert (cs_errors == 0) else report_failure("write strobe moved while cs was high");
	endtask

	task automatic seven_segment();
		logic [15:0] shown; // Registered outputs lag the count by one clock.
		logic [3:0]  nib;
		logic [2:0]  seen;
		logic        one_low;
		int          c;
		test_name = "seven_segment";
		seen      = 3'b000;
		@(negedge clk_50M);
		shown = led_count;
		for (c = 0; c < SEC_CYCLES; c++) begin
			@(negedge clk_50M);
			one_low = (display_7seg_anodes == 3'b110) || (display_7seg_anodes == 3'b101)
				|| (display_7seg_anodes == 3'b011);
			assert (one_low) else report_failure("anodes do not have exactly one digit active");
			case (display_7seg_anodes)
				3'b110:  nib = shown[3:0];
				3'b101:  nib = shown[7:4];
				default: nib = shown[11:8];
			endcase
			compare_value("segment bus", 32'({1'b1, ~seg_ref(nib)}), 32'(display_7seg_bus));
			seen  = seen | ~display_7seg_anodes;
			shown = led_count;
		end
		compare_value("digits scanned", 32'h7, 32'(seen));
	endtask

	task automatic tm1638_frame();
		logic [15:0] count;
		logic [31:0] disp;
		int          gbase;
		int          bbase;
		int          i;
		test_name = "tm1638_frame";
		wait_led_toggle();
		count = led_count;
		disp  = {count, rgb_pixel(count - 16'd1)}; // Latched before this second's pixel is written.
		gbase = tm_groups.size();
		bbase = tm_bytes.size();
		tm_groups_arrive(gbase + 3);
		compare_value("group 1 length", 32'd1, 32'(tm_groups[gbase]));
		compare_value("group 2 length", 32'd16, 32'(tm_groups[gbase + 1]));
		compare_value("group 3 length", 32'd1, 32'(tm_groups[gbase + 2]));
		compare_value("address command", 32'(ADDR_CMD), 32'(tm_bytes[bbase]));
		for (i = 0; i < 8; i++) begin
			compare_value($sformatf("digit byte %0d", 2 * i),
				32'({1'b0, seg_ref(4'(disp >> (4 * (7 - i))))}),
				32'(tm_bytes[bbase + 1 + 2 * i]));
			compare_value($sformatf("led byte %0d", 2 * i + 1), 32'(count >> i) & 32'd1,
				32'(tm_bytes[bbase + 2 + 2 * i]));
		end
		compare_value("control command", 32'(CTRL_CMD), 32'(tm_bytes[bbase + 17]));
	endtask

	initial begin
		rst_n = 1'b0;
		reset_state();
		lcd_init();
		lcd_pixel();
		seven_segment();
		tm1638_frame();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

/* logic/system.sv */
`timescale 1ns/100ps

module system #(
	parameter int CLK_PER_US = 50,
	parameter int US_PER_SEC = 1000000,
	parameter int RESET_US   = 20000,
	parameter int WR_LOW     = 3
) (
	input  logic        clk_50M,
	input  logic        rst_n,
	output logic        led,
	output logic [7:0]  display_7seg_bus,
	output logic [2:0]  display_7seg_anodes,
	output logic        tm1638_clk,
	output logic        tm1638_data,
	output logic        tm1638_strobe,
	output logic [15:0] hx8352_data,
	output logic        hx8352_rs,
	output logic        hx8352_wr,
	output logic        hx8352_rd,
	output logic        hx8352_cs,
	output logic        hx8352_rst
);
	logic        tick_us;
	logic        tick_sec;
	logic [15:0] seconds;
	logic [15:0] pixel;

	lcd_cmd_if lcd_cmd ();

	assign led = seconds[0]; // Toggles once per second.

	timebase #(.CLK_PER_US(CLK_PER_US), .US_PER_SEC(US_PER_SEC)) timebase_unit0 (
		.clk_50M (clk_50M),
		.rst_n   (rst_n),
		.tick_us (tick_us),
		.tick_sec(tick_sec),
		.seconds (seconds)
	);

	seven_segment_mux seven_segment_mux_unit0 (
		.clk_50M            (clk_50M),
		.rst_n              (rst_n),
		.tick_us            (tick_us),
		.value              (seconds[11:0]),
		.display_7seg_anodes(display_7seg_anodes),
		.display_7seg_bus   (display_7seg_bus)
	);

	tm1638_driver tm1638_driver_unit0 (
		.clk_50M      (clk_50M),
		.rst_n        (rst_n),
		.tick_us      (tick_us),
		.tick_sec     (tick_sec),
		.display_value({seconds, pixel}),
		.leds         (seconds[7:0]),
		.tm1638_strobe(tm1638_strobe),
		.tm1638_clk   (tm1638_clk),
		.tm1638_data  (tm1638_data)
	);

	hx8352_sequencer #(.RESET_US(RESET_US)) hx8352_sequencer_unit0 (
		.clk_50M (clk_50M),
		.rst_n   (rst_n),
		.tick_us (tick_us),
		.tick_sec(tick_sec),
		.seconds (seconds),
		.lcd_rst (hx8352_rst),
		.pixel   (pixel),
		.cmd     (lcd_cmd.sequencer)
	);

	hx8352_bus_writer #(.WR_LOW(WR_LOW)) hx8352_bus_writer_unit0 (
		.clk_50M    (clk_50M),
		.rst_n      (rst_n),
		.cmd        (lcd_cmd.writer),
		.hx8352_data(hx8352_data),
		.hx8352_rs  (hx8352_rs),
		.hx8352_wr  (hx8352_wr),
		.hx8352_rd  (hx8352_rd),
		.hx8352_cs  (hx8352_cs)
	);

endmodule

/* hx8352/hx8352_sequencer.sv */
`timescale 1ns/100ps

module hx8352_sequencer #(
	parameter int RESET_US = 20000
) (
	input  logic         clk_50M,
	input  logic         rst_n,
	input  logic         tick_us,
	input  logic         tick_sec,
	input  logic [15:0]  seconds,
	output logic         lcd_rst,
	output logic [15:0]  pixel,
	lcd_cmd_if.sequencer cmd
);
	import board_pkg::*;

	localparam logic [2:0] ST_BOOT     = 3'd0;
	localparam logic [2:0] ST_RST_LOW  = 3'd1;
	localparam logic [2:0] ST_RST_WAIT = 3'd2;
	localparam logic [2:0] ST_INIT     = 3'd3;
	localparam logic [2:0] ST_RUN      = 3'd4;

	logic [2:0] state;
	logic [2:0] idx;
	logic       half;    // Second word of a pair.
	logic       pending;
	logic       start_q;
	logic       rs_q;
	logic       delay_start;
	logic       delay_done;
	logic       can_send;
	lcd_word_t  entry;
	lcd_word_t  pix_next;
	lcd_word_t  word_q;

	delay_timer #(.RESET_US(RESET_US)) delay_timer_unit0 (
		.clk_50M (clk_50M),
		.rst_n   (rst_n),
		.tick_us (tick_us),
		.start   (delay_start),
		.done    (delay_done)
	);

	assign entry       = INIT_TABLE[idx];
	assign can_send    = !cmd.busy && !start_q; // Busy rises one clock after start.
	assign cmd.start   = start_q;
	assign cmd.word    = word_q;
	assign cmd.is_data = rs_q;

	always_comb begin
		pix_next.pixel.red   = seconds[4:0];
		pix_next.pixel.green = '0;
		pix_next.pixel.blue  = ~seconds[4:0];
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reset, init table, then one pixel per second
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk_50M) begin
		if (!rst_n) begin
			state       <= ST_BOOT;
			idx         <= '0;
			half        <= 1'b0;
			pending     <= 1'b0;
			start_q     <= 1'b0;
			rs_q        <= 1'b0;
			delay_start <= 1'b0;
			lcd_rst     <= 1'b0;
			word_q      <= '0;
			pixel       <= '0;
		end else begin
			delay_start <= 1'b0;
			start_q     <= 1'b0;
			case (state)
				ST_BOOT: begin
					delay_start <= 1'b1;
					state       <= ST_RST_LOW;
				end
				ST_RST_LOW: begin
					if (delay_done) begin
						lcd_rst     <= 1'b1;
						delay_start <= 1'b1; // Settle time after reset.
						state       <= ST_RST_WAIT;
					end
				end
				ST_RST_WAIT: begin
					if (delay_done)
						state <= ST_INIT;
				end
				ST_INIT: begin
					if (can_send) begin
						start_q <= 1'b1;
						rs_q    <= half;
						half    <= !half;
						word_q  <= half ? {8'h00, entry.regs.reg_value}
						                : {8'h00, entry.regs.reg_index};
						if (half) begin
							if (idx == 3'(INIT_COUNT - 1))
								state <= ST_RUN;
							else
								idx <= idx + 1'b1;
						end
					end
				end
				default: begin
					if (tick_sec)
						pending <= 1'b1; // Already set means dropped.
					if (pending && can_send) begin
						start_q <= 1'b1;
						rs_q    <= half;
						half    <= !half;
						if (!half) begin
							word_q <= {8'h00, GRAM_INDEX};
						end else begin
							word_q  <= pix_next;
							pixel   <= pix_next;
							pending <= 1'b0;
						end
					end
				end
			endcase
		end
	end

endmodule

/* hx8352/hx8352_bus_writer.sv */
`timescale 1ns/100ps

module hx8352_bus_writer #(
	parameter int WR_LOW = 3
) (
	input  logic        clk_50M,
	input  logic        rst_n,
	lcd_cmd_if.writer   cmd,
	output logic [15:0] hx8352_data,
	output logic        hx8352_rs,
	output logic        hx8352_wr,
	output logic        hx8352_rd,
	output logic        hx8352_cs
);
	localparam int CW = $clog2(WR_LOW + 2);

	logic [CW-1:0] cycle;
	logic          busy;
	logic          accept;

	assign accept    = cmd.start && !busy;
	assign cmd.busy  = busy;
	assign hx8352_rd = 1'b1; // Write-only bus.

	always_ff @(posedge clk_50M) begin
		if (accept)
			hx8352_data <= cmd.word;
	end

	always_ff @(posedge clk_50M) begin
		if (!rst_n) begin
			busy      <= 1'b0;
			cycle     <= '0;
			hx8352_cs <= 1'b1;
			hx8352_wr <= 1'b1;
			hx8352_rs <= 1'b1;
		end else if (accept) begin
			busy      <= 1'b1;
			cycle     <= '0;
			hx8352_cs <= 1'b0; // Data and rs settle with cs.
			hx8352_rs <= cmd.is_data;
		end else if (busy) begin
			cycle <= cycle + 1'b1;
			if (cycle == '0)
				hx8352_wr <= 1'b0;
			if (cycle == CW'(WR_LOW))
				hx8352_wr <= 1'b1; // Panel latches on this edge.
			if (cycle == CW'(WR_LOW + 1)) begin
				hx8352_cs <= 1'b1;
				busy      <= 1'b0;
			end
		end
	end

endmodule

/* display/tm1638_driver.sv */
`timescale 1ns/100ps

module tm1638_driver (
	input  logic        clk_50M,
	input  logic        rst_n,
	input  logic        tick_us,
	input  logic        tick_sec,
	input  logic [31:0] display_value,
	input  logic [7:0]  leds,
	output logic        tm1638_strobe,
	output logic        tm1638_clk,
	output logic        tm1638_data
);
	import board_pkg::*;

	localparam logic [1:0] ST_IDLE   = 2'd0;
	localparam logic [1:0] ST_GAP    = 2'd1;
	localparam logic [1:0] ST_SHIFT  = 2'd2;
	localparam logic [1:0] ST_STOP   = 2'd3;
	localparam logic [4:0] LAST_BYTE = 5'd17;

	logic [1:0]  state;
	logic        load;
	logic        phase;
	logic        gap_cnt;
	logic [4:0]  byte_idx;
	logic [2:0]  bit_idx;
	logic [31:0] disp_q;
	logic [7:0]  leds_q;
	logic [4:0]  disp_idx;
	logic [2:0]  nibble_sel;
	logic [7:0]  cur_byte;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Frame bytes: 0 address, 1..16 display RAM, 17 control
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign disp_idx   = byte_idx - 5'd1;
	assign nibble_sel = 3'd7 - disp_idx[3:1]; // Leftmost digit first.

	always_comb begin
		if (byte_idx == 5'd0)
			cur_byte = TM_CMD_ADDR;
		else if (byte_idx == LAST_BYTE)
			cur_byte = TM_CMD_CTRL;
		else if (!disp_idx[0])
			cur_byte = {1'b0, seg_pattern(disp_q[4*nibble_sel +: 4])};
		else
			cur_byte = {7'd0, leds_q[disp_idx[3:1]]};
	end

	always_ff @(posedge clk_50M) begin
		if (load) begin
			disp_q <= display_value;
			leds_q <= leds;
		end
	end

	always_ff @(posedge clk_50M) begin
		if (!rst_n) begin
			state         <= ST_IDLE;
			load          <= 1'b0;
			phase         <= 1'b0;
			gap_cnt       <= 1'b0;
			byte_idx      <= '0;
			bit_idx       <= '0;
			tm1638_strobe <= 1'b1;
			tm1638_clk    <= 1'b1;
			tm1638_data   <= 1'b1;
		end else begin
			load <= tick_sec && (state == ST_IDLE); // Ignored mid-frame.
			if (load) begin
				state    <= ST_GAP;
				gap_cnt  <= 1'b0;
				byte_idx <= '0;
				bit_idx  <= '0;
				phase    <= 1'b0;
			end else if (tick_us) begin
				case (state)
					ST_GAP: begin
						if (gap_cnt) begin
							gap_cnt <= 1'b0;
						end else begin
							tm1638_strobe <= 1'b0;
							state         <= ST_SHIFT;
						end
					end
					ST_SHIFT: begin
						phase <= !phase;
						if (!phase) begin
							tm1638_clk  <= 1'b0;
							tm1638_data <= cur_byte[bit_idx]; // LSB first.
						end else begin
							tm1638_clk <= 1'b1;
							bit_idx    <= bit_idx + 1'b1;
							if (bit_idx == 3'd7) begin
								byte_idx <= byte_idx + 1'b1;
								if (byte_idx == 5'd0 || byte_idx == 5'd16 || byte_idx == LAST_BYTE)
									state <= ST_STOP;
							end
						end
					end
					ST_STOP: begin
						tm1638_strobe <= 1'b1;
						gap_cnt       <= 1'b1; // Two ticks high between groups.
						state         <= (byte_idx > LAST_BYTE) ? ST_IDLE : ST_GAP;
					end
					default: ;
				endcase
			end
		end
	end

endmodule

/* display/seven_segment_mux.sv */
`timescale 1ns/100ps

module seven_segment_mux (
	input  logic        clk_50M,
	input  logic        rst_n,
	input  logic        tick_us,
	input  logic [11:0] value,
	output logic [2:0]  display_7seg_anodes,
	output logic [7:0]  display_7seg_bus
);
	import board_pkg::*;

	logic [1:0] digit;
	logic       active;
	logic [3:0] nibble;

	assign nibble = value[4*digit +: 4];

	always_ff @(posedge clk_50M) begin
		if (!rst_n) begin
			digit               <= '0;
			active              <= 1'b0;
			display_7seg_anodes <= 3'b111;
			display_7seg_bus    <= 8'hFF;
		end else begin
			if (tick_us) begin
				active <= 1'b1; // Scan starts on the first tick.
				if (active)
					digit <= (digit == 2'd2) ? 2'd0 : digit + 1'b1;
			end
			if (active) begin
				display_7seg_anodes <= ~(3'b001 << digit);
				display_7seg_bus    <= {1'b1, ~seg_pattern(nibble)}; // Dot stays off.
			end
		end
	end

endmodule

/* logic/delay_timer.sv */
`timescale 1ns/100ps

module delay_timer #(
	parameter int RESET_US = 20000
) (
	input  logic clk_50M,
	input  logic rst_n,
	input  logic tick_us,
	input  logic start,
	output logic done
);
	localparam int W = $clog2(RESET_US + 1);

	logic [W-1:0] remaining;
	logic         running;

	assign done = running && tick_us && (remaining == W'(1));

	always_ff @(posedge clk_50M) begin
		if (!rst_n) begin
			running   <= 1'b0;
			remaining <= '0;
		end else if (start) begin
			running   <= 1'b1;
			remaining <= W'(RESET_US);
		end else if (running && tick_us) begin
			remaining <= remaining - 1'b1;
			if (remaining == W'(1))
				running <= 1'b0;
		end
	end

endmodule

/* logic/timebase.sv */
`timescale 1ns/100ps

module timebase #(
	parameter int CLK_PER_US = 50,
	parameter int US_PER_SEC = 1000000
) (
	input  logic        clk_50M,
	input  logic        rst_n,
	output logic        tick_us,
	output logic        tick_sec,
	output logic [15:0] seconds
);
	localparam int CW = $clog2(CLK_PER_US + 1);
	localparam int UW = $clog2(US_PER_SEC + 1);

	logic [CW-1:0] clk_cnt;
	logic [UW-1:0] us_cnt;

	assign tick_sec = tick_us && (us_cnt == UW'(US_PER_SEC - 1)); // Last microsecond.

	always_ff @(posedge clk_50M) begin
		if (!rst_n) begin
			clk_cnt <= '0;
			us_cnt  <= '0;
			tick_us <= 1'b0;
			seconds <= '0;
		end else begin
			tick_us <= (clk_cnt == CW'(CLK_PER_US - 1));
			if (clk_cnt == CW'(CLK_PER_US - 1))
				clk_cnt <= '0;
			else
				clk_cnt <= clk_cnt + 1'b1;
			if (tick_sec) begin
				us_cnt  <= '0;
				seconds <= seconds + 1'b1; // Visible on the clock after tick_sec.
			end else if (tick_us) begin
				us_cnt <= us_cnt + 1'b1;
			end
		end
	end

endmodule

/* common/lcd_cmd_if.sv */
`timescale 1ns/100ps

interface lcd_cmd_if;
	import board_pkg::*;

	logic      start;   // One-cycle request, only while busy is low.
	lcd_word_t word;
	logic      is_data; // Drives rs.
	logic      busy;

	modport sequencer (
		output start,
		output word,
		output is_data,
		input  busy
	);

	modport writer (
		input  start,
		input  word,
		input  is_data,
		output busy
	);

endinterface

/* common/board_pkg.sv */
package board_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// HX8352 LCD
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef union packed {
		struct packed {
			logic [7:0] reg_index;
			logic [7:0] reg_value;
		} regs;
		struct packed {
			logic [4:0] red;
			logic [5:0] green;
			logic [4:0] blue;
		} pixel;
	} lcd_word_t;

	localparam int         INIT_COUNT = 6;
	localparam logic [7:0] GRAM_INDEX = 8'h22;

	localparam lcd_word_t INIT_TABLE [INIT_COUNT] = '{
		16'h1A02, // Step-up factor.
		16'h1B88, // VREG level.
		16'h2300,
		16'h1836, // Oscillator setup.
		16'h1901, // Oscillator on.
		16'h2838  // Display on.
	};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Segment displays
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam logic [7:0] TM_CMD_ADDR = 8'hC0; // Start at display address 0.
	localparam logic [7:0] TM_CMD_CTRL = 8'h8C; // Display on, level 4.

	// bit 0 is segment a, bit 6 is segment g
	localparam logic [6:0] SEG_ROM [16] = '{
		7'h3F, 7'h06, 7'h5B, 7'h4F,
		7'h66, 7'h6D, 7'h7D, 7'h07,
		7'h7F, 7'h6F, 7'h77, 7'h7C,
		7'h39, 7'h5E, 7'h79, 7'h71
	};

	function automatic logic [6:0] seg_pattern(input logic [3:0] nibble);
		return SEG_ROM[nibble];
	endfunction

endpackage
